/* control.sv */
// control unit, decodes the opcode into the control struct used down the pipe
`timescale 1ns/1ps
`default_nettype none

module control (
	input mipsPkg::opcode_t opcode,
	output mipsPkg::ctrl_t ctrl
);

	// supported opcodes
	localparam mipsPkg::opcode_t OP_RTYPE = 6'h00;
	localparam mipsPkg::opcode_t OP_J = 6'h02;
	localparam mipsPkg::opcode_t OP_JAL = 6'h03;
	localparam mipsPkg::opcode_t OP_BEQ = 6'h04;
	localparam mipsPkg::opcode_t OP_ADDI = 6'h08;
	localparam mipsPkg::opcode_t OP_SUBI = 6'h09;
	localparam mipsPkg::opcode_t OP_LW = 6'h23;
	localparam mipsPkg::opcode_t OP_SW = 6'h2b;

	always_comb begin
		// start from a bubble so every field is defined
		ctrl = '0;
		case (opcode)
			OP_RTYPE: begin
				// funct picks the operation in execute
				ctrl.regDst = mipsPkg::DST_RD;
				ctrl.memToReg = mipsPkg::WB_ALU;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = mipsPkg::ALU_FUNCT;
			end
			OP_LW: begin
				// base plus sign extended offset
				ctrl.aluSrc = 1'b1;
				ctrl.regDst = mipsPkg::DST_RT;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = mipsPkg::WB_MEM;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = mipsPkg::ALU_ADD;
			end
			OP_SW: begin
				ctrl.aluSrc = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.aluOp = mipsPkg::ALU_ADD;
			end
			OP_BEQ: begin
				// rs minus rt, taken on zero
				ctrl.aluSrc = 1'b0;
				ctrl.branch = 1'b1;
				ctrl.aluOp = mipsPkg::ALU_SUB;
			end
			OP_J: begin
				ctrl.jump = 1'b1;
				ctrl.aluOp = mipsPkg::ALU_PASS;
			end
			OP_JAL: begin
				// link goes to r31 with pc+4
				ctrl.jump = 1'b1;
				ctrl.regDst = mipsPkg::DST_RA;
				ctrl.memToReg = mipsPkg::WB_PC4;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = mipsPkg::ALU_PASS;
			end
			OP_ADDI: begin
				ctrl.aluSrc = 1'b1;
				ctrl.regDst = mipsPkg::DST_RT;
				ctrl.memToReg = mipsPkg::WB_ALU;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = mipsPkg::ALU_ADD;
			end
			OP_SUBI: begin
				ctrl.aluSrc = 1'b1;
				ctrl.regDst = mipsPkg::DST_RT;
				ctrl.memToReg = mipsPkg::WB_ALU;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = mipsPkg::ALU_SUB;
			end
			default: begin
				// unknown opcode stays a bubble
				ctrl = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* decodeStage.sv */
// decode stage, register file, control lookup, hazard interlock, decode/execute register
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
	input logic clk,
	input logic rst,
	input mipsPkg::ifId_t ifId,
	input logic redirect,
	input logic wbEn,
	input mipsPkg::regIdx_t wbReg,
	input mipsPkg::word_t wbData,
	output logic stall,
	output mipsPkg::idEx_t idEx
);

	mipsPkg::word_t regs [0:31];
	mipsPkg::ctrl_t ctrl;
	mipsPkg::regIdx_t rs;
	mipsPkg::regIdx_t rt;
	mipsPkg::regIdx_t rd;
	mipsPkg::regIdx_t dest;
	mipsPkg::word_t rsData;
	mipsPkg::word_t rtData;
	mipsPkg::word_t imm;
	mipsPkg::word_t pcPlus4;
	mipsPkg::word_t jumpTarget;
	logic usesRs;
	logic usesRt;
	logic idExWrites;

	// instruction fields
	assign rs = ifId.instr[25:21];
	assign rt = ifId.instr[20:16];
	assign rd = ifId.instr[15:11];

	control u_control (
		.opcode(ifId.instr[31:26]),
		.ctrl(ctrl)
	);

	// register file, r0 never written
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wbEn && wbReg != 5'd0) begin
			regs[wbReg] <= wbData;
		end
	end

	// reads see a same cycle write
	assign rsData = (rs == 5'd0) ? '0 :
		(wbEn && wbReg == rs) ? wbData : regs[rs];
	assign rtData = (rt == 5'd0) ? '0 :
		(wbEn && wbReg == rt) ? wbData : regs[rt];

	assign imm = {{16{ifId.instr[15]}}, ifId.instr[15:0]};
	assign pcPlus4 = ifId.pc + 32'd4;
	// pseudo direct target from the upper pc+4 bits
	assign jumpTarget = {pcPlus4[31:28], ifId.instr[25:0], 2'b00};

	always_comb begin
		case (ctrl.regDst)
			mipsPkg::DST_RD: dest = rd;
			mipsPkg::DST_RA: dest = 5'd31;
			default: dest = rt;
		endcase
	end

	// source usage, jumps read nothing
	assign usesRs = !ctrl.jump && (ctrl.regWrite || ctrl.memWrite || ctrl.branch);
	assign usesRt = (ctrl.aluOp == mipsPkg::ALU_FUNCT) || ctrl.memWrite || ctrl.branch;

	// older instruction still in execute, r0 excluded
	assign idExWrites = idEx.valid && idEx.ctrl.regWrite && (idEx.dest != 5'd0);
	assign stall = ifId.valid && idExWrites &&
		((usesRs && rs == idEx.dest) || (usesRt && rt == idEx.dest));

	always_ff @(posedge clk) begin
		// bubble on stall, flush or empty slot
		if (rst || redirect || stall || !ifId.valid) begin
			idEx.valid <= 1'b0;
		end else begin
			idEx.valid <= 1'b1;
		end
	end

	// payload is don't care under a bubble
	always_ff @(posedge clk) begin
		idEx.ctrl <= ctrl;
		idEx.pc <= ifId.pc;
		idEx.rsData <= rsData;
		idEx.rtData <= rtData;
		idEx.imm <= imm;
		idEx.funct <= ifId.instr[5:0];
		idEx.dest <= dest;
		idEx.jumpTarget <= jumpTarget;
	end

endmodule

`default_nettype wire

/* executeStage.sv */
// execute stage with the ALU, branch and jump resolution and the execute/writeback register
`timescale 1ns/1ps
`default_nettype none

module executeStage (
	input logic clk,
	input logic rst,
	input mipsPkg::idEx_t idEx,
	output logic redirect,
	output mipsPkg::word_t target,
	output mipsPkg::exWb_t exWb
);

	// R-format funct codes
	localparam mipsPkg::funct_t FN_SUB = 6'h22;
	localparam mipsPkg::funct_t FN_AND = 6'h24;
	localparam mipsPkg::funct_t FN_OR = 6'h25;
	localparam mipsPkg::funct_t FN_SLT = 6'h2a;

	mipsPkg::word_t opA;
	mipsPkg::word_t opB;
	mipsPkg::word_t result;
	mipsPkg::word_t pcPlus4;
	mipsPkg::word_t branchTarget;
	logic branchTaken;

	assign opA = idEx.rsData;
	// immediate for memory and addi/subi, rt otherwise
	assign opB = idEx.ctrl.aluSrc ? idEx.imm : idEx.rtData;

	always_comb begin
		case (idEx.ctrl.aluOp)
			mipsPkg::ALU_ADD: result = opA + opB;
			mipsPkg::ALU_SUB: result = opA - opB;
			mipsPkg::ALU_FUNCT: begin
				case (idEx.funct)
					FN_SUB: result = opA - opB;
					FN_AND: result = opA & opB;
					FN_OR: result = opA | opB;
					// signed compare
					FN_SLT: result = {31'd0, $signed(opA) < $signed(opB)};
					// add and every other funct code
					default: result = opA + opB;
				endcase
			end
			default: result = opB;
		endcase
	end

	assign pcPlus4 = idEx.pc + 32'd4;
	assign branchTarget = pcPlus4 + {idEx.imm[29:0], 2'b00};
	// beq equal when the difference is zero
	assign branchTaken = idEx.ctrl.branch && (result == '0);

	// flushes fetch and decode for this cycle
	assign redirect = idEx.valid && (idEx.ctrl.jump || branchTaken);
	assign target = idEx.ctrl.jump ? idEx.jumpTarget : branchTarget;

	always_ff @(posedge clk) begin
		if (rst) begin
			exWb.valid <= 1'b0;
		end else begin
			exWb.valid <= idEx.valid;
		end
	end

	always_ff @(posedge clk) begin
		exWb.ctrl <= idEx.ctrl;
		exWb.aluResult <= result;
		// sw writes rt
		exWb.storeData <= idEx.rtData;
		exWb.pcPlus4 <= pcPlus4;
		exWb.dest <= idEx.dest;
	end

endmodule

`default_nettype wire

/* fetchStage.sv */
// fetch stage, pc register, instruction memory with load port, fetch/decode register
`timescale 1ns/1ps
`default_nettype none
`include "mipsCore_cfg.svh"

module fetchStage (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic redirect,
	input mipsPkg::word_t target,
	input logic imemWe,
	input logic [`IMEM_ADDR_BITS-1:0] imemAddr,
	input mipsPkg::word_t imemData,
	output mipsPkg::ifId_t ifId
);

	mipsPkg::word_t imem [0:(1 << `IMEM_ADDR_BITS)-1];
	mipsPkg::word_t pc;
	logic [`IMEM_ADDR_BITS-1:0] pcIdx;

	// word index, upper pc bits ignored so fetch wraps
	assign pcIdx = pc[`WORD_OFFSET_BITS +: `IMEM_ADDR_BITS];

	// program load port
	always_ff @(posedge clk) begin
		if (imemWe) begin
			imem[imemAddr] <= imemData;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `RESET_PC;
			ifId.valid <= 1'b0;
		end else if (redirect) begin
			// taken transfer in execute, drop the fetched word
			pc <= target;
			ifId.valid <= 1'b0;
		end else if (!stall) begin
			pc <= pc + 32'd4;
			ifId.valid <= 1'b1;
		end
	end

	// payload follows the pc, held on stall
	always_ff @(posedge clk) begin
		if (!stall || redirect) begin
			ifId.pc <= pc;
			ifId.instr <= imem[pcIdx];
		end
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
mipsPkg.sv
control.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memWbStage.sv
mipsCore.sv
tbMipsCore.sv

/* memWbStage.sv */
// memory and writeback stage, data memory, writeback select, retire strobes
`timescale 1ns/1ps
`default_nettype none
`include "mipsCore_cfg.svh"

module memWbStage (
	input logic clk,
	input mipsPkg::exWb_t exWb,
	output logic wbEn,
	output mipsPkg::regIdx_t wbReg,
	output mipsPkg::word_t wbData,
	output logic storeEn,
	output mipsPkg::word_t storeAddr,
	output mipsPkg::word_t storeData
);

	mipsPkg::word_t dmem [0:(1 << `DMEM_ADDR_BITS)-1];
	logic [`DMEM_ADDR_BITS-1:0] memIdx;
	mipsPkg::word_t memData;

	// word index, wraps at the end of data memory
	assign memIdx = exWb.aluResult[`WORD_OFFSET_BITS +: `DMEM_ADDR_BITS];

	always_ff @(posedge clk) begin
		if (storeEn) begin
			dmem[memIdx] <= exWb.storeData;
		end
	end

	// combinational read, lw only
	assign memData = exWb.ctrl.memRead ? dmem[memIdx] : '0;

	always_comb begin
		case (exWb.ctrl.memToReg)
			mipsPkg::WB_MEM: wbData = memData;
			mipsPkg::WB_PC4: wbData = exWb.pcPlus4;
			default: wbData = exWb.aluResult;
		endcase
	end

	// retire strobes, r0 writes stay silent
	assign wbEn = exWb.valid && exWb.ctrl.regWrite && (exWb.dest != 5'd0);
	assign wbReg = exWb.dest;
	assign storeEn = exWb.valid && exWb.ctrl.memWrite;
	assign storeAddr = exWb.aluResult;
	assign storeData = exWb.storeData;

endmodule

`default_nettype wire

/* mipsCore.sv */
// four stage mips core, fetch, decode, execute and memory/writeback in a row
`timescale 1ns/1ps
`default_nettype none
`include "mipsCore_cfg.svh"

module mipsCore (
	input logic clk,
	input logic rst,
	input logic imemWe,
	input logic [`IMEM_ADDR_BITS-1:0] imemAddr,
	input mipsPkg::word_t imemData,
	output logic wbEn,
	output mipsPkg::regIdx_t wbReg,
	output mipsPkg::word_t wbData,
	output logic storeEn,
	output mipsPkg::word_t storeAddr,
	output mipsPkg::word_t storeData
);

	// forward path
	mipsPkg::ifId_t ifId;
	mipsPkg::idEx_t idEx;
	mipsPkg::exWb_t exWb;
	// backward path
	logic stall;
	logic redirect;
	mipsPkg::word_t target;

	fetchStage u_fetchStage (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.redirect(redirect),
		.target(target),
		.imemWe(imemWe),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.ifId(ifId)
	);

	decodeStage u_decodeStage (
		.clk(clk),
		.rst(rst),
		.ifId(ifId),
		.redirect(redirect),
		.wbEn(wbEn),
		.wbReg(wbReg),
		.wbData(wbData),
		.stall(stall),
		.idEx(idEx)
	);

	executeStage u_executeStage (
		.clk(clk),
		.rst(rst),
		.idEx(idEx),
		.redirect(redirect),
		.target(target),
		.exWb(exWb)
	);

	// writeback strobes also feed the register file
	memWbStage u_memWbStage (
		.clk(clk),
		.exWb(exWb),
		.wbEn(wbEn),
		.wbReg(wbReg),
		.wbData(wbData),
		.storeEn(storeEn),
		.storeAddr(storeAddr),
		.storeData(storeData)
	);

endmodule

`default_nettype wire

/* mipsCore_cfg.svh */
// mips core sizing and reset configuration shared by stages and testbench
`ifndef MIPSCORE_CFG_SVH
`define MIPSCORE_CFG_SVH

// instruction memory holds 2**IMEM_ADDR_BITS words
`define IMEM_ADDR_BITS 6

// data memory holds 2**DMEM_ADDR_BITS words
`define DMEM_ADDR_BITS 6

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// both memories are word addressed, byte offset bits dropped
`define WORD_OFFSET_BITS 2

`endif

/* mipsPkg.sv */
// mips core types for words, register indices, control and pipeline registers
`default_nettype none

package mipsPkg;

	// data and address word
	typedef logic [31:0] word_t;
	typedef logic [4:0] regIdx_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	// operation class handed from control to execute
	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_FUNCT,
		ALU_PASS
	} aluOp_t;

	// destination register select
	typedef enum logic [1:0] {
		DST_RT,
		DST_RD,
		DST_RA
	} regDst_t;

	// writeback data select
	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_PC4
	} wbSel_t;

	// all zero means a bubble that touches nothing
	typedef struct packed {
		logic aluSrc;
		regDst_t regDst;
		logic memWrite;
		logic memRead;
		logic branch;
		logic jump;
		wbSel_t memToReg;
		logic regWrite;
		aluOp_t aluOp;
	} ctrl_t;

	// fetch to decode
	typedef struct packed {
		logic valid;
		word_t pc;
		word_t instr;
	} ifId_t;

	// decode to execute
	typedef struct packed {
		logic valid;
		ctrl_t ctrl;
		word_t pc;
		word_t rsData;
		word_t rtData;
		word_t imm;
		funct_t funct;
		regIdx_t dest;
		word_t jumpTarget;
	} idEx_t;

	// execute to memory/writeback
	typedef struct packed {
		logic valid;
		ctrl_t ctrl;
		word_t aluResult;
		word_t storeData;
		word_t pcPlus4;
		regIdx_t dest;
	} exWb_t;

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the mips core testbench with verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module tbMipsCore -o simMipsCore \
	> build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/simMipsCore > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0

/* tbMipsCore.sv */
// mips core testbench comparing retired events with an ISA model
`timescale 1ns/1ps
`default_nettype none
`include "mipsCore_cfg.svh"

module tbMipsCore;

	localparam int IMEM_WORDS = 1 << `IMEM_ADDR_BITS;
	localparam int DMEM_WORDS = 1 << `DMEM_ADDR_BITS;
	localparam int RESET_CYCLES = 8;
	localparam int IDLE_LIMIT = 60;
	localparam int QUIET_CYCLES = 40;
	localparam int MODEL_STEP_LIMIT = 4096;
	localparam int RANDOM_PROGRAMS = 4;
	localparam int RANDOM_BLOCK = 50;

	// ISA encodings
	localparam mipsPkg::opcode_t OP_RTYPE = 6'h00;
	localparam mipsPkg::opcode_t OP_J = 6'h02;
	localparam mipsPkg::opcode_t OP_JAL = 6'h03;
	localparam mipsPkg::opcode_t OP_BEQ = 6'h04;
	localparam mipsPkg::opcode_t OP_ADDI = 6'h08;
	localparam mipsPkg::opcode_t OP_SUBI = 6'h09;
	localparam mipsPkg::opcode_t OP_LW = 6'h23;
	localparam mipsPkg::opcode_t OP_SW = 6'h2b;
	localparam mipsPkg::opcode_t OP_BAD = 6'h3f;
	localparam mipsPkg::funct_t FN_ADD = 6'h20;
	localparam mipsPkg::funct_t FN_SUB = 6'h22;
	localparam mipsPkg::funct_t FN_AND = 6'h24;
	localparam mipsPkg::funct_t FN_OR = 6'h25;
	localparam mipsPkg::funct_t FN_SLT = 6'h2a;

	// retired event whose key is the register number or the store address
	typedef struct packed {
		logic isStore;
		mipsPkg::word_t key;
		mipsPkg::word_t data;
	} retire_t;

	logic clk;
	logic rst;
	logic imemWe;
	logic [`IMEM_ADDR_BITS-1:0] imemAddr;
	mipsPkg::word_t imemData;
	logic wbEn;
	mipsPkg::regIdx_t wbReg;
	mipsPkg::word_t wbData;
	logic storeEn;
	mipsPkg::word_t storeAddr;
	mipsPkg::word_t storeData;

	mipsPkg::word_t prog [$];
	mipsPkg::word_t progMem [0:IMEM_WORDS-1];
	// model data memory persists across programs just as the core's does
	mipsPkg::word_t modelMem [0:DMEM_WORDS-1];
	bit memKnown [0:DMEM_WORDS-1];
	int knownIdx [$];
	retire_t expected [$];

	mipsCore u_mipsCore (
		.clk(clk),
		.rst(rst),
		.imemWe(imemWe),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.wbEn(wbEn),
		.wbReg(wbReg),
		.wbData(wbData),
		.storeEn(storeEn),
		.storeAddr(storeAddr),
		.storeData(storeData)
	);

	// 8 ns clock
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	function automatic mipsPkg::word_t encR(input mipsPkg::regIdx_t rs,
		input mipsPkg::regIdx_t rt, input mipsPkg::regIdx_t rd, input mipsPkg::funct_t fn);
		return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic mipsPkg::word_t encI(input mipsPkg::opcode_t op,
		input mipsPkg::regIdx_t rs, input mipsPkg::regIdx_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// j and jal take a word address
	function automatic mipsPkg::word_t encJ(input mipsPkg::opcode_t op, input int wordAddr);
		return {op, wordAddr[25:0]};
	endfunction

	function automatic void put(input mipsPkg::word_t w);
		prog.push_back(w);
	endfunction

	function automatic int pick(input int n);
		return int'($urandom % n);
	endfunction

	// small register pool so hazards show up often
	function automatic mipsPkg::regIdx_t randReg();
		return mipsPkg::regIdx_t'($urandom % 8);
	endfunction

	function automatic mipsPkg::funct_t randFunct();
		case (pick(5))
			0: return FN_SUB;
			1: return FN_AND;
			2: return FN_OR;
			3: return FN_SLT;
			default: return FN_ADD;
		endcase
	endfunction

	// random upper bits alias the same word through the wrap
	function automatic logic [15:0] memOffset(input int idx);
		logic [15:0] off;
		off = 16'($urandom);
		off[`DMEM_ADDR_BITS+1:2] = idx[`DMEM_ADDR_BITS-1:0];
		off[1:0] = 2'b00;
		return off;
	endfunction

	// sw from r0 base marks the word safe to load
	function automatic void putStore(input int idx);
		put(encI(OP_SW, 5'd0, randReg(), memOffset(idx)));
		if (!memKnown[idx]) begin
			memKnown[idx] = 1'b1;
			knownIdx.push_back(idx);
		end
	endfunction

	// park the core on a jump to itself and pad the rest with zero
	task automatic finishProgram();
		put(encJ(OP_J, prog.size()));
		assert (prog.size() <= IMEM_WORDS) else begin
			abortRun("program does not fit in instruction memory");
		end
		for (int i = 0; i < IMEM_WORDS; i++) begin
			if (i < prog.size()) begin
				progMem[i] = prog[i];
			end else begin
				progMem[i] = '0;
			end
		end
	endtask

	task automatic buildDirectedProgram();
		prog.delete();
		put(encI(OP_ADDI, 5'd0, 5'd1, 16'd5));
		// -3
		put(encI(OP_ADDI, 5'd0, 5'd2, 16'hfffd));
		// back to back users of r2
		put(encR(5'd1, 5'd2, 5'd3, FN_ADD));
		put(encR(5'd2, 5'd1, 5'd4, FN_SUB));
		put(encR(5'd1, 5'd2, 5'd5, FN_AND));
		put(encR(5'd1, 5'd2, 5'd6, FN_OR));
		put(encR(5'd2, 5'd1, 5'd7, FN_SLT));
		put(encR(5'd1, 5'd2, 5'd8, FN_SLT));
		// subi with -7
		put(encI(OP_SUBI, 5'd1, 5'd9, 16'hfff9));
		put(encI(OP_ADDI, 5'd1, 5'd0, 16'd1));
		put(encI(OP_SW, 5'd0, 5'd3, 16'd8));
		put(encI(OP_LW, 5'd0, 5'd10, 16'd8));
		// load use
		put(encR(5'd10, 5'd10, 5'd11, FN_ADD));
		// 260 wraps onto word 1
		put(encI(OP_SW, 5'd0, 5'd4, 16'd260));
		put(encI(OP_LW, 5'd0, 5'd12, 16'd4));
		put(encI(OP_BEQ, 5'd1, 5'd2, 16'd2));
		put(encI(OP_ADDI, 5'd0, 5'd13, 16'd1));
		put(encI(OP_BEQ, 5'd3, 5'd3, 16'd2));
		put(encI(OP_ADDI, 5'd0, 5'd14, 16'd99));
		put(encI(OP_ADDI, 5'd0, 5'd15, 16'd99));
		put(encJ(OP_J, 23));
		put(encI(OP_ADDI, 5'd0, 5'd14, 16'd77));
		put(encI(OP_ADDI, 5'd0, 5'd15, 16'd77));
		put(encJ(OP_JAL, 26));
		put(encI(OP_ADDI, 5'd0, 5'd16, 16'd55));
		put(encI(OP_ADDI, 5'd0, 5'd16, 16'd56));
		put(encR(5'd31, 5'd0, 5'd17, FN_ADD));
		// countdown loop with a backward j and a taken beq
		put(encI(OP_ADDI, 5'd0, 5'd18, 16'd2));
		put(encI(OP_SUBI, 5'd18, 5'd18, 16'd1));
		put(encI(OP_BEQ, 5'd18, 5'd0, 16'd1));
		put(encJ(OP_J, 28));
		put({OP_BAD, 26'h3ff_ffff});
		finishProgram();
	endtask

	task automatic buildRandomProgram();
		prog.delete();
		// prologue seeds r1..r7
		for (int r = 1; r < 8; r++) begin
			put(encI(OP_ADDI, 5'd0, 5'(r), 16'($urandom)));
		end
		for (int s = 0; s < 4; s++) begin
			putStore(pick(DMEM_WORDS));
		end
		for (int n = 0; n < RANDOM_BLOCK; n++) begin
			case (pick(9))
				5: put(encI(OP_ADDI, randReg(), randReg(), 16'($urandom)));
				6: put(encI(OP_SUBI, randReg(), randReg(), 16'($urandom)));
				7: putStore(pick(DMEM_WORDS));
				8: put(encI(OP_LW, 5'd0, randReg(), memOffset(knownIdx[pick(knownIdx.size())])));
				default: put(encR(randReg(), randReg(), randReg(), randFunct()));
			endcase
		end
		finishProgram();
	endtask

	// instruction-set model filling the expected event list in program order
	function automatic bit runModel();
		mipsPkg::word_t regs [0:31];
		mipsPkg::word_t pc;
		mipsPkg::word_t instr;
		mipsPkg::word_t a;
		mipsPkg::word_t b;
		mipsPkg::word_t imm;
		mipsPkg::word_t addr;
		mipsPkg::word_t res;
		mipsPkg::word_t nextPc;
		mipsPkg::regIdx_t dest;
		logic doWrite;
		logic done;
		int steps;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		pc = `RESET_PC;
		done = 1'b0;
		steps = 0;
		while (!done && steps < MODEL_STEP_LIMIT) begin
			// word fetch wrapping at the end of memory
			instr = progMem[pc[`WORD_OFFSET_BITS +: `IMEM_ADDR_BITS]];
			a = regs[instr[25:21]];
			b = regs[instr[20:16]];
			imm = {{16{instr[15]}}, instr[15:0]};
			addr = a + imm;
			nextPc = pc + 32'd4;
			res = '0;
			dest = instr[20:16];
			doWrite = 1'b0;
			case (instr[31:26])
				OP_RTYPE: begin
					dest = instr[15:11];
					doWrite = 1'b1;
					case (instr[5:0])
						FN_ADD: res = a + b;
						FN_SUB: res = a - b;
						FN_AND: res = a & b;
						FN_OR: res = a | b;
						FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: doWrite = 1'b0;
					endcase
				end
				OP_ADDI: begin
					res = a + imm;
					doWrite = 1'b1;
				end
				OP_SUBI: begin
					res = a - imm;
					doWrite = 1'b1;
				end
				OP_LW: begin
					res = modelMem[addr[`WORD_OFFSET_BITS +: `DMEM_ADDR_BITS]];
					doWrite = 1'b1;
				end
				OP_SW: begin
					modelMem[addr[`WORD_OFFSET_BITS +: `DMEM_ADDR_BITS]] = b;
					expected.push_back(retire_t'{1'b1, addr, b});
				end
				OP_BEQ: begin
					if (a == b) begin
						nextPc = pc + 32'd4 + (imm << 2);
					end
				end
				OP_J, OP_JAL: begin
					nextPc = {nextPc[31:28], instr[25:0], 2'b00};
					// jump onto itself ends the program
					if (instr[31:26] == OP_J && nextPc == pc) begin
						done = 1'b1;
					end
					if (instr[31:26] == OP_JAL) begin
						res = pc + 32'd4;
						dest = 5'd31;
						doWrite = 1'b1;
					end
				end
				default: begin
					// unknown opcode does nothing
				end
			endcase
			// r0 stays zero and silent
			if (doWrite && dest != 5'd0) begin
				regs[dest] = res;
				expected.push_back(retire_t'{1'b0, {27'd0, dest}, res});
			end
			pc = nextPc;
			steps++;
		end
		return done;
	endfunction

	// load while reset is high and hold reset 8 more cycles
	task automatic loadProgram();
		@(posedge clk);
		#1;
		rst = 1'b1;
		for (int i = 0; i < IMEM_WORDS; i++) begin
			imemWe = 1'b1;
			imemAddr = i[`IMEM_ADDR_BITS-1:0];
			imemData = progMem[i];
			@(posedge clk);
			#1;
		end
		imemWe = 1'b0;
		repeat (RESET_CYCLES) begin
			@(posedge clk);
		end
		#1;
		rst = 1'b0;
	endtask

	// idle timeout restarts on every retired event
	task automatic waitForRetirement();
		int idle;
		int lastSize;
		idle = 0;
		lastSize = expected.size();
		while (expected.size() > 0 && idle < IDLE_LIMIT) begin
			@(posedge clk);
			if (expected.size() != lastSize) begin
				lastSize = expected.size();
				idle = 0;
			end else begin
				idle++;
			end
		end
		if (expected.size() > 0) begin
			abortRun($sformatf("core stopped retiring with %0d events still expected",
				expected.size()));
		end
		// core must stay silent on the final self-jump
		repeat (QUIET_CYCLES) begin
			@(posedge clk);
		end
	endtask

	task automatic runProgram(input string name);
		bit finished;
		expected.delete();
		finished = runModel();
		assert (finished) else begin
			abortRun("reference model never reached the final self-jump");
		end
		$display("%s program, %0d events expected", name, expected.size());
		loadProgram();
		waitForRetirement();
	endtask

	task automatic checkRetire(input logic isStore, input mipsPkg::word_t key,
		input mipsPkg::word_t data);
		retire_t want;
		assert (expected.size() > 0) else begin
			abortRun("an extra event retired after the expected list ran out");
		end
		want = expected.pop_front();
		assert (want.isStore == isStore) else begin
			abortRun(isStore ? "a store retired where a register write was expected" :
				"a register write retired where a store was expected");
		end
		if (isStore) begin
			assert (want.key == key) else begin
				abortRun($sformatf("Fail storeAddr expected %h actual %h", want.key, key));
			end
			assert (want.data == data) else begin
				abortRun($sformatf("Fail storeData expected %h actual %h", want.data, data));
			end
		end else begin
			assert (want.key[4:0] == key[4:0]) else begin
				abortRun($sformatf("Fail wbReg expected %h actual %h", want.key[4:0], key[4:0]));
			end
			assert (want.data == data) else begin
				abortRun($sformatf("Fail wbData expected %h actual %h", want.data, data));
			end
		end
	endtask

	// strobes settle mid cycle and are sampled on the falling edge
	always @(negedge clk) begin
		if (rst === 1'b0) begin
			assert (!$isunknown({wbEn, storeEn})) else begin
				abortRun("retire strobes went unknown");
			end
			if (wbEn) begin
				checkRetire(1'b0, {27'd0, wbReg}, wbData);
			end
			if (storeEn) begin
				checkRetire(1'b1, storeAddr, storeData);
			end
		end
	end

	initial begin
		rst = 1'b1;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		void'($urandom(32'had18));
		buildDirectedProgram();
		runProgram("directed");
		for (int p = 0; p < RANDOM_PROGRAMS; p++) begin
			buildRandomProgram();
			runProgram($sformatf("random %0d", p));
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire
